// ==== hw/ethPktConsts.svh ====
/*
 * Ethernet packet buffer constants
 * Bus and RAM widths, buffer depth, maximum packet length,
 * register address map and status word layout
 */
`ifndef ETH_PKT_CONSTS_SVH
`define ETH_PKT_CONSTS_SVH

// ---------------------------------------------------------------------------
// Bus and buffer geometry
// ---------------------------------------------------------------------------
`define ETH_BUS_WIDTH 16
`define ETH_ADDR_WIDTH 13
// Each buffer RAM holds 2048 words of 16 bits
`define ETH_RAM_WORDS 2048
`define ETH_RAM_ADDR_WIDTH 11
// Largest length the streamer will send, in bytes
`define ETH_MAX_PKT_BYTES 4096
// Wide enough to hold the full maximum count
`define ETH_TX_CNT_WIDTH 13

// ---------------------------------------------------------------------------
// Register address map
// ---------------------------------------------------------------------------
`define ETH_ADDR_STATUS 2048
`define ETH_ADDR_RX_READY 2049
`define ETH_ADDR_TX_START 2050
`define ETH_ADDR_TX_LEN 2051
// MAC1 and MAC2 follow at the next two addresses
`define ETH_ADDR_MAC0 2053
// IP1 follows at the next address
`define ETH_ADDR_IP0 2056
`define ETH_ADDR_PORT 2061
`define ETH_ADDR_TEST 2062
`define ETH_ADDR_TX_COUNT 2066
`define ETH_ADDR_TX_COUNT_CLR 2068
// Transmit RAM bus window, 2048 words from here
`define ETH_TX_RAM_BASE 4096

// Status word: bit 15 always set, ready flag here, rest zero
`define ETH_STATUS_READY_BIT 13

`endif

// ==== hw/ethPktPkg.sv ====
/*
 * Shared types of the Ethernet packet buffer
 * Bus request, exported configuration and bus word union
 */
`include "ethPktConsts.svh"

package ethPktPkg;

	// -----------------------------------------------------------------------
	// Local bus
	// -----------------------------------------------------------------------
	// One bus cycle as seen by the slave
	typedef struct packed {
		logic select;
		// High for a write, low for a read
		logic write;
		logic strobe;
		logic [`ETH_ADDR_WIDTH-1:0] addr;
		logic [`ETH_BUS_WIDTH-1:0] data;
	} busReq_t;

	// -----------------------------------------------------------------------
	// Configuration handed to the header builder
	// -----------------------------------------------------------------------
	// MAC word 0 is the most significant part
	typedef struct packed {
		logic [3*`ETH_BUS_WIDTH-1:0] macAddr;
		logic [2*`ETH_BUS_WIDTH-1:0] ipAddr;
		logic [`ETH_BUS_WIDTH-1:0] udpPort;
	} moduleConfig_t;

	// -----------------------------------------------------------------------
	// Buffer word
	// -----------------------------------------------------------------------
	// Network order, high byte goes out first
	typedef struct packed {
		logic [7:0] hiByte;
		logic [7:0] loByte;
	} busBytes_t;

	// Same stored word seen as a bus value or as two stream bytes
	typedef union packed {
		logic [`ETH_BUS_WIDTH-1:0] raw;
		busBytes_t bytes;
	} busWord_u;

endpackage

// ==== hw/bufferRam.sv ====
/*
 * Packet buffer RAM
 * Word write port, registered word read port for the bus,
 * registered byte read port for the transmit streamer
 */
`timescale 1ns/1ps
`include "ethPktConsts.svh"

module bufferRam (
	input  logic Clock,
	// Bus write side
	input  logic wrEn_i,
	input  logic [`ETH_RAM_ADDR_WIDTH-1:0] wrAddr_i,
	input  ethPktPkg::busWord_u wrData_i,
	// Bus read side
	input  logic [`ETH_RAM_ADDR_WIDTH-1:0] rdAddr_i,
	output ethPktPkg::busWord_u rdData_o,
	// Streamer read side, one address per byte
	input  logic [`ETH_RAM_ADDR_WIDTH:0] byteAddr_i,
	output logic [7:0] byteData_o
);

	ethPktPkg::busWord_u mem [0:`ETH_RAM_WORDS-1];
	ethPktPkg::busWord_u byteWord;

	// Word holding the requested byte
	assign byteWord = mem[byteAddr_i[`ETH_RAM_ADDR_WIDTH:1]];

	always_ff @(posedge Clock) begin
		if (wrEn_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
	end

	// Bus readback, one cycle after the address
	always_ff @(posedge Clock) begin
		rdData_o <= mem[rdAddr_i];
	end

	// Even byte address gives the high byte
	always_ff @(posedge Clock) begin
		if (byteAddr_i[0]) begin
			byteData_o <= byteWord.bytes.loByte;
		end else begin
			byteData_o <= byteWord.bytes.hiByte;
		end
	end

endmodule

// ==== hw/busRegisterFile.sv ====
/*
 * Local bus slave of the packet buffer
 * Address decode, RAM write enables, control and configuration
 * registers, transmitted packet counter and registered read mux
 */
`timescale 1ns/1ps
`include "ethPktConsts.svh"

module busRegisterFile (
	input  logic Clock,
	input  logic rst_i,
	input  ethPktPkg::busReq_t busReq_i,
	output logic [`ETH_BUS_WIDTH-1:0] busData_o,
	// RAM side
	output logic rxWrEn_o,
	output logic txWrEn_o,
	output logic [`ETH_RAM_ADDR_WIDTH-1:0] ramRdAddr_o,
	input  ethPktPkg::busWord_u rxRdData_i,
	input  ethPktPkg::busWord_u txRdData_i,
	// Control
	input  logic intStart_i,
	input  logic txDone_i,
	output logic txStart_o,
	output logic [`ETH_BUS_WIDTH-1:0] txLenBytes_o,
	output logic rxReady_o,
	output ethPktPkg::moduleConfig_t moduleConfig_o
);

	logic wrCycle;
	logic rdCycle;
	logic inRxWin;
	logic inTxWin;
	logic rxReady;
	logic [`ETH_BUS_WIDTH-1:0] txLen;
	logic [`ETH_BUS_WIDTH-1:0] mac0;
	logic [`ETH_BUS_WIDTH-1:0] mac1;
	logic [`ETH_BUS_WIDTH-1:0] mac2;
	logic [`ETH_BUS_WIDTH-1:0] ip0;
	logic [`ETH_BUS_WIDTH-1:0] ip1;
	logic [`ETH_BUS_WIDTH-1:0] udpPort;
	logic [`ETH_BUS_WIDTH-1:0] testReg;
	logic [`ETH_BUS_WIDTH-1:0] txCount;
	logic [`ETH_BUS_WIDTH-1:0] statusWord;
	logic [`ETH_BUS_WIDTH-1:0] regRdData;
	logic [`ETH_BUS_WIDTH-1:0] regDataQ;
	logic rdRxQ;
	logic rdTxQ;

	// ------------------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------------------
	assign wrCycle = busReq_i.select & busReq_i.write & busReq_i.strobe;
	assign rdCycle = busReq_i.select & ~busReq_i.write;

	// Receive RAM sits at the bottom of the map
	assign inRxWin = (busReq_i.addr < `ETH_RAM_WORDS);
	assign inTxWin = (busReq_i.addr >= `ETH_TX_RAM_BASE) &&
		(busReq_i.addr < `ETH_TX_RAM_BASE + `ETH_RAM_WORDS);

	assign rxWrEn_o = wrCycle & inRxWin;
	assign txWrEn_o = wrCycle & inTxWin;
	// Both windows are 2048 aligned, low bits are the word address
	assign ramRdAddr_o = busReq_i.addr[`ETH_RAM_ADDR_WIDTH-1:0];

	// ------------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------------
	// Ready flag, set by the bus or by a finished transmission
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			rxReady <= 1'b0;
		end else if (intStart_i) begin
			rxReady <= 1'b0;
		end else if ((wrCycle && busReq_i.addr == `ETH_ADDR_RX_READY) || txDone_i) begin
			rxReady <= 1'b1;
		end
	end

	// Start strobe towards the streamer
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			txStart_o <= 1'b0;
		end else begin
			txStart_o <= wrCycle && (busReq_i.addr == `ETH_ADDR_TX_START);
		end
	end

	// Counts finished packets, a write to the clear address wins
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			txCount <= '0;
		end else if (wrCycle && busReq_i.addr == `ETH_ADDR_TX_COUNT_CLR) begin
			txCount <= '0;
		end else if (txDone_i) begin
			txCount <= txCount + 1'b1;
		end
	end

	// Configuration and length
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			txLen <= '0;
			mac0 <= '0;
			mac1 <= '0;
			mac2 <= '0;
			ip0 <= '0;
			ip1 <= '0;
			udpPort <= '0;
			testReg <= '0;
		end else if (wrCycle) begin
			case (busReq_i.addr)
				`ETH_ADDR_TX_LEN: txLen <= busReq_i.data;
				`ETH_ADDR_MAC0: mac0 <= busReq_i.data;
				`ETH_ADDR_MAC0 + 1: mac1 <= busReq_i.data;
				`ETH_ADDR_MAC0 + 2: mac2 <= busReq_i.data;
				`ETH_ADDR_IP0: ip0 <= busReq_i.data;
				`ETH_ADDR_IP0 + 1: ip1 <= busReq_i.data;
				`ETH_ADDR_PORT: udpPort <= busReq_i.data;
				`ETH_ADDR_TEST: testReg <= busReq_i.data;
				default: ;
			endcase
		end
	end

	assign txLenBytes_o = txLen;
	assign rxReady_o = rxReady;
	assign moduleConfig_o.macAddr = {mac0, mac1, mac2};
	assign moduleConfig_o.ipAddr = {ip0, ip1};
	assign moduleConfig_o.udpPort = udpPort;

	// ------------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------------
	always_comb begin
		statusWord = 16'h8000;
		statusWord[`ETH_STATUS_READY_BIT] = rxReady;
	end

	// Write only and unmapped addresses give zero
	always_comb begin
		case (busReq_i.addr)
			`ETH_ADDR_STATUS: regRdData = statusWord;
			`ETH_ADDR_TX_LEN: regRdData = txLen;
			`ETH_ADDR_MAC0: regRdData = mac0;
			`ETH_ADDR_MAC0 + 1: regRdData = mac1;
			`ETH_ADDR_MAC0 + 2: regRdData = mac2;
			`ETH_ADDR_IP0: regRdData = ip0;
			`ETH_ADDR_IP0 + 1: regRdData = ip1;
			`ETH_ADDR_PORT: regRdData = udpPort;
			`ETH_ADDR_TEST: regRdData = testReg;
			`ETH_ADDR_TX_COUNT: regRdData = txCount;
			default: regRdData = '0;
		endcase
	end

	// Remember the source so RAM and register data land in the same cycle
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			rdRxQ <= 1'b0;
			rdTxQ <= 1'b0;
			regDataQ <= '0;
		end else begin
			rdRxQ <= rdCycle & inRxWin;
			rdTxQ <= rdCycle & inTxWin;
			regDataQ <= rdCycle ? regRdData : '0;
		end
	end

	always_comb begin
		if (rdRxQ) begin
			busData_o = rxRdData_i.raw;
		end else if (rdTxQ) begin
			busData_o = txRdData_i.raw;
		end else begin
			busData_o = regDataQ;
		end
	end

endmodule

// ==== hw/txStreamer.sv ====
/*
 * Transmit streamer
 * Request and grant with the FIFO owner, byte counter over the
 * transmit RAM, FIFO strobe with back-pressure and end pulse
 */
`timescale 1ns/1ps
`include "ethPktConsts.svh"

module txStreamer (
	input  logic Clock,
	input  logic rst_i,
	input  logic txStart_i,
	input  logic [`ETH_BUS_WIDTH-1:0] txLenBytes_i,
	input  logic txGrant_i,
	input  logic fifoFull_i,
	// Transmit RAM byte port
	output logic [`ETH_RAM_ADDR_WIDTH:0] byteAddr_o,
	input  logic [7:0] byteData_i,
	// Outgoing FIFO side
	output logic txRequest_o,
	output logic [7:0] txData_o,
	output logic txStrobe_o,
	output logic txEnd_o,
	output logic txDone_o
);

	logic requestQ;
	logic activeQ;
	logic strobeQ;
	logic endQ;
	logic [`ETH_TX_CNT_WIDTH-1:0] byteCnt;
	logic [`ETH_TX_CNT_WIDTH-1:0] lastCnt;
	logic [`ETH_TX_CNT_WIDTH-1:0] cappedLen;
	logic advance;
	logic finished;

	// Lengths above the maximum are clipped
	always_comb begin
		if (txLenBytes_i > `ETH_MAX_PKT_BYTES) begin
			cappedLen = `ETH_TX_CNT_WIDTH'(`ETH_MAX_PKT_BYTES);
		end else begin
			cappedLen = txLenBytes_i[`ETH_TX_CNT_WIDTH-1:0];
		end
	end

	// ------------------------------------------------------------------------
	// Request and grant
	// ------------------------------------------------------------------------
	// Start is ignored while a request or a transfer is pending
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			requestQ <= 1'b0;
		end else if (requestQ && txGrant_i) begin
			requestQ <= 1'b0;
		end else if (txStart_i && !activeQ) begin
			requestQ <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Byte counter
	// ------------------------------------------------------------------------
	// A new byte address only while the FIFO has room
	assign advance = activeQ && !fifoFull_i && (byteCnt != lastCnt);
	assign finished = activeQ && (byteCnt == lastCnt);

	always_ff @(posedge Clock) begin
		if (rst_i) begin
			activeQ <= 1'b0;
			byteCnt <= '0;
		end else if (requestQ && txGrant_i) begin
			activeQ <= 1'b1;
			byteCnt <= '0;
		end else if (finished) begin
			activeQ <= 1'b0;
		end else if (advance) begin
			byteCnt <= byteCnt + 1'b1;
		end
	end

	// Length latched at grant so a bus write cannot disturb the packet
	always_ff @(posedge Clock) begin
		if (requestQ && txGrant_i) begin
			lastCnt <= cappedLen;
		end
	end

	// Below the maximum while advancing, so the top bit is always clear here
	assign byteAddr_o = byteCnt[`ETH_RAM_ADDR_WIDTH:0];

	// ------------------------------------------------------------------------
	// FIFO strobe and end
	// ------------------------------------------------------------------------
	// RAM data arrives one cycle after the address, strobe follows it
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			strobeQ <= 1'b0;
			endQ <= 1'b0;
		end else begin
			strobeQ <= advance;
			endQ <= finished;
		end
	end

	assign txRequest_o = requestQ;
	assign txData_o = byteData_i;
	assign txStrobe_o = strobeQ;
	// End and done are the same pulse, one towards the FIFO, one to the counter
	assign txEnd_o = endQ;
	assign txDone_o = endQ;

endmodule

// ==== hw/ethPktBuffer.sv ====
/*
 * Ethernet packet buffer top level
 * Receive and transmit RAMs, bus register file and transmit streamer
 */
`timescale 1ns/1ps
`include "ethPktConsts.svh"

module ethPktBuffer (
	input  logic Clock,
	input  logic rst_i,
	// Local bus
	input  ethPktPkg::busReq_t busReq_i,
	output logic [`ETH_BUS_WIDTH-1:0] busData_o,
	// Receive side
	input  logic intStart_i,
	output logic rxTxInProgress_o,
	// Settings for the header builder
	output ethPktPkg::moduleConfig_t moduleConfig_o,
	// Transmit side
	output logic txRequest_o,
	input  logic txGrant_i,
	input  logic fifoFull_i,
	output logic [7:0] txData_o,
	output logic txStrobe_o,
	output logic txEnd_o
);

	logic rxWrEn;
	logic txWrEn;
	logic [`ETH_RAM_ADDR_WIDTH-1:0] ramRdAddr;
	ethPktPkg::busWord_u rxRdData;
	ethPktPkg::busWord_u txRdData;
	logic txStart;
	logic txDone;
	logic [`ETH_BUS_WIDTH-1:0] txLenBytes;
	logic rxReady;
	logic [`ETH_RAM_ADDR_WIDTH:0] txByteAddr;
	logic [7:0] txByteData;

	// ------------------------------------------------------------------------
	// Buffers
	// ------------------------------------------------------------------------
	// Receive RAM is bus only, byte port unused
	bufferRam rxRam0 (
		.Clock(Clock),
		.wrEn_i(rxWrEn),
		.wrAddr_i(busReq_i.addr[`ETH_RAM_ADDR_WIDTH-1:0]),
		.wrData_i(busReq_i.data),
		.rdAddr_i(ramRdAddr),
		.rdData_o(rxRdData),
		.byteAddr_i('0),
		.byteData_o()
	);

	bufferRam txRam0 (
		.Clock(Clock),
		.wrEn_i(txWrEn),
		.wrAddr_i(busReq_i.addr[`ETH_RAM_ADDR_WIDTH-1:0]),
		.wrData_i(busReq_i.data),
		.rdAddr_i(ramRdAddr),
		.rdData_o(txRdData),
		.byteAddr_i(txByteAddr),
		.byteData_o(txByteData)
	);

	// ------------------------------------------------------------------------
	// Bus slave and streamer
	// ------------------------------------------------------------------------
	busRegisterFile regs0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.busReq_i(busReq_i),
		.busData_o(busData_o),
		.rxWrEn_o(rxWrEn),
		.txWrEn_o(txWrEn),
		.ramRdAddr_o(ramRdAddr),
		.rxRdData_i(rxRdData),
		.txRdData_i(txRdData),
		.intStart_i(intStart_i),
		.txDone_i(txDone),
		.txStart_o(txStart),
		.txLenBytes_o(txLenBytes),
		.rxReady_o(rxReady),
		.moduleConfig_o(moduleConfig_o)
	);

	txStreamer streamer0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.txStart_i(txStart),
		.txLenBytes_i(txLenBytes),
		.txGrant_i(txGrant_i),
		.fifoFull_i(fifoFull_i),
		.byteAddr_o(txByteAddr),
		.byteData_i(txByteData),
		.txRequest_o(txRequest_o),
		.txData_o(txData_o),
		.txStrobe_o(txStrobe_o),
		.txEnd_o(txEnd_o),
		.txDone_o(txDone)
	);

	// Busy whenever the buffer is not marked ready
	assign rxTxInProgress_o = ~rxReady;

endmodule

// ==== tests/ethPktBufferTb.sv ====
/*
 * Testbench for the Ethernet packet buffer
 * Clock and reset, bus tasks, FIFO model on the transmit side,
 * reference byte stream and checks over status, RAMs and registers
 */
`timescale 1ns/1ps
`include "ethPktConsts.svh"

module ethPktBufferTb;

	localparam int REQ_TIMEOUT = 50;
	localparam int END_TIMEOUT = 20000;

	logic Clock = 1'b0;
	logic rst_i;
	ethPktPkg::busReq_t busReq;
	logic [15:0] busData;
	logic intStart;
	logic rxTxInProgress;
	ethPktPkg::moduleConfig_t cfg;
	logic txRequest;
	logic txGrant;
	logic fifoFull;
	logic [7:0] txData;
	logic txStrobe;
	logic txEnd;

	// Models of what the bus wrote and what the stream should carry
	logic [15:0] txWords [0:`ETH_RAM_WORDS-1];
	logic [15:0] rxModel [int];
	logic [15:0] txModel [int];
	logic [7:0] expQ [$];
	logic [7:0] fifoQ [$];
	logic fullAtEdge = 1'b0;
	int endCount = 0;
	int errorCount = 0;
	int packetCount = 0;

	ethPktBuffer dut0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.busReq_i(busReq),
		.busData_o(busData),
		.intStart_i(intStart),
		.rxTxInProgress_o(rxTxInProgress),
		.moduleConfig_o(cfg),
		.txRequest_o(txRequest),
		.txGrant_i(txGrant),
		.fifoFull_i(fifoFull),
		.txData_o(txData),
		.txStrobe_o(txStrobe),
		.txEnd_o(txEnd)
	);

	// 4 ns period
	always #2 Clock = ~Clock;

	// ------------------------------------------------------------------------
	// Failure reporting and the compare task
	// ------------------------------------------------------------------------
	task automatic endWithFailure();
		$display("Finished with errors");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("ERROR: %s", msg);
		endWithFailure();
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			endWithFailure();
		end
	endtask

	// ------------------------------------------------------------------------
	// Bus cycles, called right after a falling edge
	// ------------------------------------------------------------------------
	task automatic busWrite(input logic [12:0] addr, input logic [15:0] data);
		busReq.select = 1'b1;
		busReq.write = 1'b1;
		busReq.strobe = 1'b1;
		busReq.addr = addr;
		busReq.data = data;
		@(negedge Clock);
		busReq = '0;
	endtask

	// Data is registered, so it is there one edge after the address
	task automatic busRead(input logic [12:0] addr, output logic [15:0] data);
		busReq.select = 1'b1;
		busReq.write = 1'b0;
		busReq.strobe = 1'b1;
		busReq.addr = addr;
		@(negedge Clock);
		data = busData;
		busReq = '0;
	endtask

	task automatic checkRead(input string name, input logic [12:0] addr,
		input logic [15:0] expected);
		logic [15:0] got;
		busRead(addr, got);
		checkValue(name, 64'(expected), 64'(got));
	endtask

	// ------------------------------------------------------------------------
	// Reference stream and FIFO model
	// ------------------------------------------------------------------------
	// High byte of each word first, length clipped to the maximum
	function automatic void buildExpected(input int lenBytes);
		int capped;
		int i;
		capped = (lenBytes > `ETH_MAX_PKT_BYTES) ? `ETH_MAX_PKT_BYTES : lenBytes;
		expQ.delete();
		for (i = 0; i < capped; i++) begin
			if (i % 2 == 0) begin
				expQ.push_back(txWords[i / 2][15:8]);
			end else begin
				expQ.push_back(txWords[i / 2][7:0]);
			end
		end
	endfunction

	always @(posedge Clock) begin
		fullAtEdge <= fifoFull;
	end

	// Outputs change on the rising edge and are sampled on the falling one
	always @(negedge Clock) begin
		if (txStrobe) begin
			// Only the byte already fetched may follow full
			if (fullAtEdge) begin
				reportProblem("txStrobe_o came a full cycle after fifoFull_i rose");
			end
			fifoQ.push_back(txData);
		end
		if (txEnd) begin
			checkValue("bytes before end pulse", 64'(expQ.size()), 64'(fifoQ.size()));
			endCount++;
		end
	end

	task automatic compareStream(input string name);
		int i;
		checkValue({name, " length"}, 64'(expQ.size()), 64'(fifoQ.size()));
		for (i = 0; i < expQ.size(); i++) begin
			checkValue($sformatf("%s byte %0d", name, i), 64'(expQ[i]), 64'(fifoQ[i]));
		end
	endtask

	// Load words, program the length, start, grant and wait for the end
	task automatic sendPacket(input string name, input int lenBytes, input bit useFull);
		int k;
		int cyc;
		int target;
		bit seen;
		for (k = 0; k < (lenBytes + 1) / 2; k++) begin
			txWords[k] = 16'($urandom);
			busWrite(13'(`ETH_TX_RAM_BASE + k), txWords[k]);
		end
		buildExpected(lenBytes);
		fifoQ.delete();
		busWrite(13'(`ETH_ADDR_TX_LEN), 16'(lenBytes));
		busWrite(13'(`ETH_ADDR_TX_START), 16'h0000);
		seen = 1'b0;
		for (cyc = 0; cyc < REQ_TIMEOUT && !seen; cyc++) begin
			if (txRequest) begin
				seen = 1'b1;
			end else begin
				@(negedge Clock);
			end
		end
		if (!seen) begin
			reportProblem({name, ": txRequest_o never rose after the start write"});
		end
		txGrant = 1'b1;
		@(negedge Clock);
		txGrant = 1'b0;
		checkValue({name, " request after grant"}, 64'd0, 64'(txRequest));
		target = endCount + 1;
		seen = 1'b0;
		for (cyc = 0; cyc < END_TIMEOUT && !seen; cyc++) begin
			@(posedge Clock);
			if (endCount == target) begin
				seen = 1'b1;
			end
			@(negedge Clock);
			fifoFull = useFull && ($urandom_range(2) == 0);
		end
		fifoFull = 1'b0;
		if (!seen) begin
			reportProblem({name, ": txEnd_o never arrived"});
		end
		// A second end pulse would show up here
		repeat (3) @(negedge Clock);
		checkValue({name, " end pulses"}, 64'(target), 64'(endCount));
		compareStream(name);
		packetCount++;
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [15:0] word;
		logic [15:0] macWords [0:2];
		logic [15:0] ipWords [0:1];
		logic [15:0] portWord;
		logic [15:0] testWord;
		logic [15:0] lenWord;
		int i;
		int addr;
		void'($urandom(32));
		rst_i = 1'b1;
		busReq = '0;
		intStart = 1'b0;
		txGrant = 1'b0;
		fifoFull = 1'b0;
		repeat (5) @(negedge Clock);
		rst_i = 1'b0;

		// Status word and ready flag
		checkRead("status after reset", 13'(`ETH_ADDR_STATUS), 16'h8000);
		checkValue("busy after reset", 64'd1, 64'(rxTxInProgress));
		busWrite(13'(`ETH_ADDR_RX_READY), 16'h0001);
		checkRead("status when ready", 13'(`ETH_ADDR_STATUS), 16'hA000);
		checkValue("busy when ready", 64'd0, 64'(rxTxInProgress));
		intStart = 1'b1;
		@(negedge Clock);
		intStart = 1'b0;
		checkRead("status after intStart", 13'(`ETH_ADDR_STATUS), 16'h8000);
		checkValue("busy after intStart", 64'd1, 64'(rxTxInProgress));

		// Random words into both RAM windows
		for (i = 0; i < 16; i++) begin
			addr = $urandom_range(`ETH_RAM_WORDS - 1);
			word = 16'($urandom);
			busWrite(13'(addr), word);
			rxModel[addr] = word;
			addr = $urandom_range(`ETH_RAM_WORDS - 1);
			word = 16'($urandom);
			busWrite(13'(`ETH_TX_RAM_BASE + addr), word);
			txModel[addr] = word;
		end
		foreach (rxModel[a]) begin
			checkRead($sformatf("rx RAM word %0d", a), 13'(a), rxModel[a]);
		end
		foreach (txModel[a]) begin
			checkRead($sformatf("tx RAM word %0d", a), 13'(`ETH_TX_RAM_BASE + a), txModel[a]);
		end
		checkRead("unmapped address", 13'd3000, 16'h0000);

		// Configuration, test and length registers
		for (i = 0; i < 3; i++) begin
			macWords[i] = 16'($urandom);
			busWrite(13'(`ETH_ADDR_MAC0 + i), macWords[i]);
		end
		for (i = 0; i < 2; i++) begin
			ipWords[i] = 16'($urandom);
			busWrite(13'(`ETH_ADDR_IP0 + i), ipWords[i]);
		end
		portWord = 16'($urandom);
		testWord = 16'($urandom);
		lenWord = 16'($urandom);
		busWrite(13'(`ETH_ADDR_PORT), portWord);
		busWrite(13'(`ETH_ADDR_TEST), testWord);
		busWrite(13'(`ETH_ADDR_TX_LEN), lenWord);
		for (i = 0; i < 3; i++) begin
			checkRead($sformatf("MAC word %0d", i), 13'(`ETH_ADDR_MAC0 + i), macWords[i]);
		end
		for (i = 0; i < 2; i++) begin
			checkRead($sformatf("IP word %0d", i), 13'(`ETH_ADDR_IP0 + i), ipWords[i]);
		end
		checkRead("UDP port", 13'(`ETH_ADDR_PORT), portWord);
		checkRead("test word", 13'(`ETH_ADDR_TEST), testWord);
		checkRead("tx length", 13'(`ETH_ADDR_TX_LEN), lenWord);
		checkValue("config MAC", 64'({macWords[0], macWords[1], macWords[2]}),
			64'(cfg.macAddr));
		checkValue("config IP", 64'({ipWords[0], ipWords[1]}), 64'(cfg.ipAddr));
		checkValue("config port", 64'(portWord), 64'(cfg.udpPort));

		// Transmissions, the last one empty
		sendPacket("single packet", $urandom_range(200, 1), 1'b0);
		sendPacket("back-pressure packet A", $urandom_range(300, 1), 1'b1);
		sendPacket("back-pressure packet B", $urandom_range(300, 1), 1'b1);
		sendPacket("empty packet", 0, 1'b0);

		// Packet counter and its clear
		checkRead("packet counter", 13'(`ETH_ADDR_TX_COUNT), 16'(packetCount));
		busWrite(13'(`ETH_ADDR_TX_COUNT_CLR), 16'h0000);
		checkRead("packet counter after clear", 13'(`ETH_ADDR_TX_COUNT), 16'h0000);

		if (errorCount == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			endWithFailure();
		end
	end

endmodule

// ==== all.f ====
+incdir+hw
hw/ethPktPkg.sv
hw/bufferRam.sv
hw/busRegisterFile.sv
hw/txStreamer.sv
hw/ethPktBuffer.sv
tests/ethPktBufferTb.sv

// ==== Makefile ====
# Verilator build and run of the Ethernet packet buffer testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= ethPktBufferTb
RTL_TOP ?= ethPktBuffer
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Finished with no errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) hw/ethPktConsts.svh
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides, the simulator exit status is not trusted
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
